// File: rtl/iq_pkg.sv
/*
  Shared types and default sizes for the integer issue queue.
  Register index width is fixed here; physical register 0 is never busy
  and doubles as the "no source" index.
*/
`default_nettype none

package iq_pkg;

  // Three pipes, each with its own special class
  localparam int ISSUE_WIDTH = 3;

  // Top-level defaults, 8 slots and 2 lanes also supported
  localparam int IQ_SIZE_DEFAULT        = 16;
  localparam int DISPATCH_WIDTH_DEFAULT = 4;

  typedef logic [5:0] prf_index_t;
  typedef logic [5:0] rob_tag_t;

  // Functional unit class of a micro-op
  typedef enum logic [1:0] {
    FU_ALU  = 2'd0,
    FU_BR   = 2'd1,
    FU_IMUL = 2'd2,
    FU_IDIV = 2'd3
  } fu_code_t;

  // Operand origin, only RF operands wait on the busy table
  typedef enum logic [1:0] {
    RS_FROM_RF  = 2'd0,
    RS_FROM_IMM = 2'd1,
    RS_FROM_PC  = 2'd2
  } rs_source_t;

  // Issue-relevant part of a micro-op, no operand values
  typedef struct packed {
    logic       valid;
    fu_code_t   fu_code;
    rs_source_t rs1_source;
    rs_source_t rs2_source;
    prf_index_t rs1_prf_index;
    prf_index_t rs2_prf_index;
    logic       rd_valid;
    prf_index_t rd_prf_index;
    rob_tag_t   rob_tag;
  } micro_op_t;

  // Register update port, used for both busy set and busy clear
  typedef struct packed {
    logic       valid;
    prf_index_t prf_index;
  } writeback_t;

endpackage

`default_nettype wire

// File: rtl/issue_slot.sv
/*
  One issue queue entry. Load and clear never hit the same slot in one cycle.
  Non-RF sources report index 0, which is never busy.
*/
`timescale 1ns/100ps
`default_nettype none

module issue_slot import iq_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       clear,
  input  logic       load,
  input  micro_op_t  uop_in,
  input  logic       busy1,
  input  logic       busy2,
  output micro_op_t  uop,
  output prf_index_t rs1_index,
  output prf_index_t rs2_index,
  output logic       ready,
  output logic       free
);

  micro_op_t payload;
  logic      occupied;

  always_ff @(posedge clock) begin
    if (reset || clear) begin
      occupied <= 1'b0;
    end else if (load) begin
      occupied <= uop_in.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      payload <= uop_in;
    end
  end

  always_comb begin
    uop = payload;
    uop.valid = occupied;
  end

  // Only register-file operands need a busy lookup
  assign rs1_index = (payload.rs1_source == RS_FROM_RF) ? payload.rs1_prf_index : '0;
  assign rs2_index = (payload.rs2_source == RS_FROM_RF) ? payload.rs2_prf_index : '0;

  assign ready = occupied && !busy1 && !busy2;
  assign free  = !occupied;

endmodule

`default_nettype wire

// File: rtl/priority_picker.sv
/*
  Picks up to REQS set bits, lowest index first. WIDTH must be at least 2.
  Unused grants read index 0 with grant_valid low.
*/
`timescale 1ns/100ps
`default_nettype none

module priority_picker #(
  parameter int REQS  = 1,
  parameter int WIDTH = 16
) (
  input  logic [WIDTH-1:0]                    request,
  output logic [REQS-1:0][$clog2(WIDTH)-1:0]  grant_index,
  output logic [REQS-1:0]                     grant_valid
);

  localparam int IDX_W = $clog2(WIDTH);

  always_comb begin
    logic [WIDTH-1:0] remaining;
    remaining = request;
    for (int k = 0; k < REQS; k++) begin
      grant_valid[k] = 1'b0;
      grant_index[k] = '0;
      // Scan downward so the lowest set bit is the last one written
      for (int i = WIDTH - 1; i >= 0; i--) begin
        if (remaining[i]) begin
          grant_valid[k] = 1'b1;
          grant_index[k] = IDX_W'(i);
        end
      end
      // Mask the granted bit before the next grant
      if (grant_valid[k]) begin
        remaining[grant_index[k]] = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/slot_allocator.sv
/*
  Places valid dispatch lanes into the lowest free slots, in lane order.
  Dispatch must hold back while iq_full is high; a lane without a slot is dropped.
  iq_full counts slots free at the start of the cycle only.
*/
`timescale 1ns/100ps
`default_nettype none

module slot_allocator import iq_pkg::*; #(
  parameter int IQ_SIZE        = IQ_SIZE_DEFAULT,
  parameter int DISPATCH_WIDTH = DISPATCH_WIDTH_DEFAULT
) (
  input  micro_op_t  [DISPATCH_WIDTH-1:0] dispatch_uops,
  input  logic       [IQ_SIZE-1:0]        free,
  output logic       [IQ_SIZE-1:0]        load,
  output micro_op_t  [IQ_SIZE-1:0]        slot_uops,
  output writeback_t [DISPATCH_WIDTH-1:0] dispatch_dest,
  output logic                            iq_full
);

  localparam int IDX_W = $clog2(IQ_SIZE);
  localparam int CNT_W = $clog2(IQ_SIZE + 1);

  logic [DISPATCH_WIDTH-1:0][IDX_W-1:0] grant_index;
  logic [DISPATCH_WIDTH-1:0]            grant_valid;
  logic [CNT_W-1:0]                     free_count;

  priority_picker #(
    .REQS  (DISPATCH_WIDTH),
    .WIDTH (IQ_SIZE)
  ) free_picker (
    .request     (free),
    .grant_index (grant_index),
    .grant_valid (grant_valid)
  );

  always_comb begin
    free_count = '0;
    for (int k = 0; k < IQ_SIZE; k++) begin
      free_count = free_count + CNT_W'(free[k]);
    end
  end

  assign iq_full = free_count < CNT_W'(DISPATCH_WIDTH);

  // Compact valid lanes onto the granted slots
  always_comb begin
    int rank;
    rank = 0;
    load = '0;
    slot_uops = '0;
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      dispatch_dest[i] = '0;
      if (dispatch_uops[i].valid) begin
        if (grant_valid[rank]) begin
          load[grant_index[rank]] = 1'b1;
          slot_uops[grant_index[rank]] = dispatch_uops[i];
          // Destination becomes busy along with the load
          dispatch_dest[i].valid = dispatch_uops[i].rd_valid;
          dispatch_dest[i].prf_index = dispatch_uops[i].rd_prf_index;
        end
        rank = rank + 1;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/busy_table.sv
/*
  Busy bit per physical register, read combinationally from the register bank.
  A dispatch set beats a writeback clear of the same register in one cycle.
  Register 0 is never set.
*/
`timescale 1ns/100ps
`default_nettype none

module busy_table import iq_pkg::*; #(
  parameter int IQ_SIZE        = IQ_SIZE_DEFAULT,
  parameter int DISPATCH_WIDTH = DISPATCH_WIDTH_DEFAULT
) (
  input  logic                            clock,
  input  logic                            reset,
  input  writeback_t [DISPATCH_WIDTH-1:0] dispatch_dest,
  input  writeback_t [ISSUE_WIDTH-1:0]    writeback,
  input  prf_index_t [IQ_SIZE-1:0]        rs1_index,
  input  prf_index_t [IQ_SIZE-1:0]        rs2_index,
  output logic       [IQ_SIZE-1:0]        rs1_busy,
  output logic       [IQ_SIZE-1:0]        rs2_busy
);

  localparam int PRF_COUNT = 1 << $bits(prf_index_t);

  logic [PRF_COUNT-1:0] busy;
  logic [PRF_COUNT-1:0] busy_next;

  always_comb begin
    busy_next = busy;
    // Clears first so a later set overrides
    for (int w = 0; w < ISSUE_WIDTH; w++) begin
      if (writeback[w].valid) begin
        busy_next[writeback[w].prf_index] = 1'b0;
      end
    end
    for (int d = 0; d < DISPATCH_WIDTH; d++) begin
      if (dispatch_dest[d].valid && (dispatch_dest[d].prf_index != '0)) begin
        busy_next[dispatch_dest[d].prf_index] = 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= '0;
    end else begin
      busy <= busy_next;
    end
  end

  // Two read ports per slot
  always_comb begin
    for (int k = 0; k < IQ_SIZE; k++) begin
      rs1_busy[k] = busy[rs1_index[k]];
      rs2_busy[k] = busy[rs2_index[k]];
    end
  end

endmodule

`default_nettype wire

// File: rtl/issue_arbiter.sv
/*
  Chooses up to one micro-op per pipe. Pipe p prefers its special class
  (branch, multiply, divide) over ALU grant p. A busy pipe issues nothing and
  its ALU grant is not passed on to another pipe.
*/
`timescale 1ns/100ps
`default_nettype none

module issue_arbiter import iq_pkg::*; #(
  parameter int IQ_SIZE = IQ_SIZE_DEFAULT
) (
  input  logic      [IQ_SIZE-1:0]     ready,
  input  micro_op_t [IQ_SIZE-1:0]     slot_uops,
  input  logic      [ISSUE_WIDTH-1:0] ex_busy,
  output micro_op_t [ISSUE_WIDTH-1:0] issue_uops,
  output logic      [IQ_SIZE-1:0]     clear
);

  localparam int IDX_W = $clog2(IQ_SIZE);

  logic [IQ_SIZE-1:0]                   ready_alu;
  logic [ISSUE_WIDTH-1:0][IQ_SIZE-1:0]  ready_special;
  logic [ISSUE_WIDTH-1:0][IDX_W-1:0]    special_index;
  logic [ISSUE_WIDTH-1:0]               special_valid;
  logic [ISSUE_WIDTH-1:0][IDX_W-1:0]    alu_index;
  logic [ISSUE_WIDTH-1:0]               alu_valid;

  always_comb begin
    for (int k = 0; k < IQ_SIZE; k++) begin
      ready_alu[k] = ready[k] && (slot_uops[k].fu_code == FU_ALU);
    end
  end

  // One picker per pipe for its own unit class
  for (genvar p = 0; p < ISSUE_WIDTH; p++) begin : g_special
    localparam fu_code_t PIPE_FU = (p == 0) ? FU_BR : ((p == 1) ? FU_IMUL : FU_IDIV);

    always_comb begin
      for (int k = 0; k < IQ_SIZE; k++) begin
        ready_special[p][k] = ready[k] && (slot_uops[k].fu_code == PIPE_FU);
      end
    end

    priority_picker #(
      .REQS  (1),
      .WIDTH (IQ_SIZE)
    ) special_picker (
      .request     (ready_special[p]),
      .grant_index (special_index[p]),
      .grant_valid (special_valid[p])
    );
  end

  // Ranking ignores ex_busy, ALU grant k belongs to pipe k
  priority_picker #(
    .REQS  (ISSUE_WIDTH),
    .WIDTH (IQ_SIZE)
  ) alu_picker (
    .request     (ready_alu),
    .grant_index (alu_index),
    .grant_valid (alu_valid)
  );

  always_comb begin
    logic [IDX_W-1:0] pick_index;
    logic             pick_valid;
    clear = '0;
    for (int p = 0; p < ISSUE_WIDTH; p++) begin
      issue_uops[p] = '0;
      pick_valid = special_valid[p] || alu_valid[p];
      pick_index = special_valid[p] ? special_index[p] : alu_index[p];
      if (pick_valid && !ex_busy[p]) begin
        clear[pick_index] = 1'b1;
        issue_uops[p] = slot_uops[pick_index];
        issue_uops[p].valid = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/issue_queue_int.sv
/*
  Integer issue queue, three pipes (branch/ALU, mul/ALU, div/ALU).
  Dispatch must send nothing while iq_full is high. Issue is combinational
  from slot state; no flush or speculative wakeup.
*/
`timescale 1ns/100ps
`default_nettype none

module issue_queue_int import iq_pkg::*; #(
  parameter int IQ_SIZE        = IQ_SIZE_DEFAULT,
  parameter int DISPATCH_WIDTH = DISPATCH_WIDTH_DEFAULT
) (
  input  logic                            clock,
  input  logic                            reset,
  input  micro_op_t  [DISPATCH_WIDTH-1:0] dispatch_uops,
  output logic                            iq_full,
  input  logic       [ISSUE_WIDTH-1:0]    ex_busy,
  input  writeback_t [ISSUE_WIDTH-1:0]    writeback,
  output micro_op_t  [ISSUE_WIDTH-1:0]    issue_uops
);

  logic       [IQ_SIZE-1:0]        free;
  logic       [IQ_SIZE-1:0]        load;
  logic       [IQ_SIZE-1:0]        clear;
  logic       [IQ_SIZE-1:0]        ready;
  micro_op_t  [IQ_SIZE-1:0]        load_uops;
  micro_op_t  [IQ_SIZE-1:0]        slot_uops;
  prf_index_t [IQ_SIZE-1:0]        rs1_index;
  prf_index_t [IQ_SIZE-1:0]        rs2_index;
  logic       [IQ_SIZE-1:0]        rs1_busy;
  logic       [IQ_SIZE-1:0]        rs2_busy;
  writeback_t [DISPATCH_WIDTH-1:0] dispatch_dest;

  for (genvar k = 0; k < IQ_SIZE; k++) begin : g_slot
    issue_slot slot (
      .clock     (clock),
      .reset     (reset),
      .clear     (clear[k]),
      .load      (load[k]),
      .uop_in    (load_uops[k]),
      .busy1     (rs1_busy[k]),
      .busy2     (rs2_busy[k]),
      .uop       (slot_uops[k]),
      .rs1_index (rs1_index[k]),
      .rs2_index (rs2_index[k]),
      .ready     (ready[k]),
      .free      (free[k])
    );
  end

  slot_allocator #(
    .IQ_SIZE        (IQ_SIZE),
    .DISPATCH_WIDTH (DISPATCH_WIDTH)
  ) allocator (
    .dispatch_uops (dispatch_uops),
    .free          (free),
    .load          (load),
    .slot_uops     (load_uops),
    .dispatch_dest (dispatch_dest),
    .iq_full       (iq_full)
  );

  busy_table #(
    .IQ_SIZE        (IQ_SIZE),
    .DISPATCH_WIDTH (DISPATCH_WIDTH)
  ) busy (
    .clock         (clock),
    .reset         (reset),
    .dispatch_dest (dispatch_dest),
    .writeback     (writeback),
    .rs1_index     (rs1_index),
    .rs2_index     (rs2_index),
    .rs1_busy      (rs1_busy),
    .rs2_busy      (rs2_busy)
  );

  issue_arbiter #(
    .IQ_SIZE (IQ_SIZE)
  ) arbiter (
    .ready      (ready),
    .slot_uops  (slot_uops),
    .ex_busy    (ex_busy),
    .issue_uops (issue_uops),
    .clear      (clear)
  );

endmodule

`default_nettype wire

// File: test/iq_ref_model.svh
/*
  Reference model of the issue queue, included inside the testbench module.
  Tracks slot contents and busy bits; uses the testbench input signals.
*/
`ifndef IQ_REF_MODEL_SVH
`define IQ_REF_MODEL_SVH

micro_op_t          model_slot [IQ_SIZE];
logic [63:0]        model_busy;
micro_op_t          exp_issue [ISSUE_WIDTH];
logic [IQ_SIZE-1:0] exp_clear;
logic               exp_full;

function automatic logic source_ok(rs_source_t src, prf_index_t idx);
  return (src != RS_FROM_RF) || !model_busy[idx];
endfunction

function automatic logic slot_ready(int k);
  return model_slot[k].valid
    && source_ok(model_slot[k].rs1_source, model_slot[k].rs1_prf_index)
    && source_ok(model_slot[k].rs2_source, model_slot[k].rs2_prf_index);
endfunction

function automatic int occupied_count();
  int n;
  n = 0;
  for (int k = 0; k < IQ_SIZE; k++) n += model_slot[k].valid;
  return n;
endfunction

function automatic void clear_model();
  for (int k = 0; k < IQ_SIZE; k++) model_slot[k] = '0;
  model_busy = '0;
endfunction

// Expected issue and full for the current cycle
function automatic void predict_outputs();
  int       alu_rank;
  fu_code_t special;
  logic [ISSUE_WIDTH-1:0] special_found;
  alu_rank = 0;
  special_found = '0;
  exp_clear = '0;
  exp_full = (IQ_SIZE - occupied_count()) < DISPATCH_WIDTH;
  for (int p = 0; p < ISSUE_WIDTH; p++) begin
    exp_issue[p] = '0;
    special = (p == 0) ? FU_BR : ((p == 1) ? FU_IMUL : FU_IDIV);
    for (int k = 0; k < IQ_SIZE; k++) begin
      if (slot_ready(k) && model_slot[k].fu_code == special && !special_found[p]) begin
        special_found[p] = 1'b1;
        if (!ex_busy[p]) begin
          exp_issue[p] = model_slot[k];
          exp_clear[k] = 1'b1;
        end
      end
    end
  end
  // ALU rank k goes to pipe k only
  for (int k = 0; k < IQ_SIZE; k++) begin
    if (slot_ready(k) && model_slot[k].fu_code == FU_ALU) begin
      if (alu_rank < ISSUE_WIDTH && !special_found[alu_rank] && !ex_busy[alu_rank]) begin
        exp_issue[alu_rank] = model_slot[k];
        exp_clear[k] = 1'b1;
      end
      alu_rank++;
    end
  end
endfunction

// State after the coming clock edge
function automatic void advance_model();
  logic [IQ_SIZE-1:0] taken;
  for (int k = 0; k < IQ_SIZE; k++) taken[k] = model_slot[k].valid;
  for (int k = 0; k < IQ_SIZE; k++) if (exp_clear[k]) model_slot[k] = '0;
  for (int i = 0; i < DISPATCH_WIDTH; i++) begin
    if (dispatch_uops[i].valid) begin
      for (int k = 0; k < IQ_SIZE; k++) begin
        if (!taken[k]) begin
          taken[k] = 1'b1;
          model_slot[k] = dispatch_uops[i];
          break;
        end
      end
    end
  end
  for (int w = 0; w < ISSUE_WIDTH; w++)
    if (writeback[w].valid) model_busy[writeback[w].prf_index] = 1'b0;
  for (int i = 0; i < DISPATCH_WIDTH; i++)
    if (dispatch_uops[i].valid && dispatch_uops[i].rd_valid && dispatch_uops[i].rd_prf_index != 0)
      model_busy[dispatch_uops[i].rd_prf_index] = 1'b1;
endfunction

`endif

// File: test/tb_issue_queue_int.sv
/*
  Testbench for the integer issue queue. Directed phases, then LFSR random mix,
  then a drain; every cycle is compared against the included reference model.
*/
`timescale 1ns/100ps
`default_nettype none

module tb_issue_queue_int import iq_pkg::*; ();

  localparam int IQ_SIZE        = IQ_SIZE_DEFAULT;
  localparam int DISPATCH_WIDTH = DISPATCH_WIDTH_DEFAULT;
  localparam int RANDOM_CYCLES  = 400;
  localparam int TOTAL_CYCLES   = 60 + RANDOM_CYCLES + 80;

  logic clock;
  logic reset;
  micro_op_t  [DISPATCH_WIDTH-1:0] dispatch_uops;
  logic                            iq_full;
  logic       [ISSUE_WIDTH-1:0]    ex_busy;
  writeback_t [ISSUE_WIDTH-1:0]    writeback;
  micro_op_t  [ISSUE_WIDTH-1:0]    issue_uops;

  logic [31:0] lfsr_state = 32'h0c2e_7026;
  rob_tag_t    next_tag = '0;
  int          pending [64];

  `include "iq_ref_model.svh"

  issue_queue_int #(.IQ_SIZE(IQ_SIZE), .DISPATCH_WIDTH(DISPATCH_WIDTH)) dut (
    .clock(clock), .reset(reset), .dispatch_uops(dispatch_uops), .iq_full(iq_full),
    .ex_busy(ex_busy), .writeback(writeback), .issue_uops(issue_uops)
  );

  always #50 clock = ~clock;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_issue(input int pipe, input micro_op_t got, input micro_op_t exp);
    if (got !== exp) begin
      $display("Error: issue_uops[%0d] got %h expected %h", pipe, got, exp);
      fail_run("Issue output mismatch");
    end
  endtask

  task automatic check_full(input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: iq_full got %h expected %h", got, exp);
      fail_run("Full flag mismatch");
    end
  endtask

  // Galois LFSR stepped once per bit drawn
  function automatic logic [7:0] draw(input int bits);
    logic [7:0] value;
    value = '0;
    for (int b = 0; b < bits; b++) begin
      value = {value[6:0], lfsr_state[0]};
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
    end
    return value;
  endfunction

  function automatic micro_op_t make_uop(fu_code_t fu, rs_source_t src1, prf_index_t idx1,
                                         logic rdv, prf_index_t rd);
    micro_op_t u;
    u = '0;
    u.valid = 1'b1;
    u.fu_code = fu;
    u.rs1_source = src1;
    u.rs1_prf_index = idx1;
    u.rs2_source = RS_FROM_IMM;
    u.rd_valid = rdv;
    u.rd_prf_index = rd;
    u.rob_tag = next_tag;
    next_tag = next_tag + 1'b1;
    return u;
  endfunction

  task automatic next_cycle();
    @(posedge clock);
    #10;
    dispatch_uops = '0;
    writeback = '0;
  endtask

  // Compare just before the edge, then advance the model
  always @(negedge clock) begin
    if (reset) begin
      clear_model();
    end else begin
      predict_outputs();
      check_full(iq_full, exp_full);
      for (int p = 0; p < ISSUE_WIDTH; p++) begin
        check_issue(p, issue_uops[p], exp_issue[p]);
        if (issue_uops[p].valid) begin
          if (pending[issue_uops[p].rob_tag] == 0) fail_run("A tag issued more often than sent");
          pending[issue_uops[p].rob_tag]--;
        end
      end
      for (int i = 0; i < DISPATCH_WIDTH; i++)
        if (dispatch_uops[i].valid) pending[dispatch_uops[i].rob_tag]++;
      advance_model();
    end
  end

  initial begin
    #((TOTAL_CYCLES + 50) * 100);
    fail_run("Timeout, the test did not finish in time");
  end

  initial begin
    int lanes;
    int wb;
    for (int t = 0; t < 64; t++) pending[t] = 0;
    reset = 1'b1;
    clock = 1'b0;
    dispatch_uops = '0;
    ex_busy = '0;
    writeback = '0;
    repeat (2) @(posedge clock);
    #10 reset = 1'b0;
    // Independent ALU ops issue three at a time in the next cycle
    next_cycle();
    for (int i = 0; i < DISPATCH_WIDTH; i++)
      dispatch_uops[i] = make_uop(FU_ALU, RS_FROM_IMM, 6'd0, 1'b0, 6'd0);
    repeat (3) next_cycle();
    // Special classes win their pipes
    dispatch_uops[0] = make_uop(FU_ALU, RS_FROM_PC, 6'd5, 1'b0, 6'd0);
    dispatch_uops[1] = make_uop(FU_BR, RS_FROM_IMM, 6'd0, 1'b0, 6'd0);
    dispatch_uops[2] = make_uop(FU_IMUL, RS_FROM_IMM, 6'd0, 1'b0, 6'd0);
    dispatch_uops[3] = make_uop(FU_IDIV, RS_FROM_IMM, 6'd0, 1'b1, 6'd5);
    next_cycle();
    // Waits on register 5 until its writeback
    dispatch_uops[0] = make_uop(FU_ALU, RS_FROM_RF, 6'd5, 1'b0, 6'd0);
    repeat (4) next_cycle();
    writeback[1] = '{valid: 1'b1, prf_index: 6'd5};
    repeat (3) next_cycle();
    // Back-pressure on pipe 0, then fill the queue
    ex_busy = 3'b001;
    for (int i = 0; i < DISPATCH_WIDTH; i++)
      dispatch_uops[i] = make_uop(FU_ALU, RS_FROM_IMM, 6'd0, 1'b0, 6'd0);
    repeat (3) next_cycle();
    ex_busy = 3'b111;
    for (int c = 0; c < 8; c++) begin
      if (!iq_full)
        for (int i = 0; i < DISPATCH_WIDTH; i++)
          dispatch_uops[i] = make_uop(FU_ALU, RS_FROM_IMM, 6'd0, 1'b0, 6'd0);
      next_cycle();
    end
    ex_busy = 3'b000;
    repeat (6) next_cycle();
    // Random mix
    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      lanes = draw(3) % (DISPATCH_WIDTH + 1);
      if (!iq_full)
        for (int i = 0; i < lanes; i++) begin
          dispatch_uops[i] = make_uop(fu_code_t'(draw(2)), rs_source_t'(2'(draw(2) % 3)),
                                      prf_index_t'(draw(3)), 1'(draw(1)), prf_index_t'(draw(3)));
          dispatch_uops[i].rs2_source = rs_source_t'(2'(draw(2) % 3));
          dispatch_uops[i].rs2_prf_index = prf_index_t'(draw(3));
        end
      ex_busy = 3'(draw(3) & draw(3));
      for (int w = 0; w < ISSUE_WIDTH; w++) begin
        wb = draw(3);
        if (draw(1) && model_busy[wb]) writeback[w] = '{valid: 1'b1, prf_index: 6'(wb)};
      end
      next_cycle();
    end
    // Drain by releasing every busy register
    ex_busy = 3'b000;
    while (occupied_count() != 0 || model_busy != 0) begin
      wb = 0;
      for (int r = 1; r < 8; r++)
        if (model_busy[r] && wb < ISSUE_WIDTH) begin
          writeback[wb] = '{valid: 1'b1, prf_index: 6'(r)};
          wb++;
        end
      next_cycle();
    end
    next_cycle();
    lanes = 0;
    for (int t = 0; t < 64; t++) lanes += pending[t];
    if (lanes == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      fail_run("Some dispatched tags never issued");
    end
  end

endmodule

`default_nettype wire

// File: issue_queue_int.f
+incdir+test
rtl/iq_pkg.sv
rtl/issue_slot.sv
rtl/priority_picker.sv
rtl/slot_allocator.sv
rtl/busy_table.sv
rtl/issue_arbiter.sv
rtl/issue_queue_int.sv
test/tb_issue_queue_int.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the issue queue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_issue_queue_int \
  -f issue_queue_int.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression passed" sim.log; then
  exit 0
else
  exit 1
fi
